// File: sim/corePatterns.txt
// program words from @00, stall bitmap from @80, records from @90
// record = kind<<8 | reg, then value (kind 1 writeback, 2 branch pc, 3 fault pc, 0 end)
@00
61000005 // addi r1, r0, 5
6200FFFD // addi r2, r0, -3
13120000 // add r3, r1, r2
24310000 // sub r4, r3, r1
35410000 // and r5, r4, r1
46520000 // or r6, r5, r2
57610000 // xor r7, r6, r1
68001234 // addi r8, r0, 0x1234
69804321 // addi r9, r8, 0x4321
7A890000 // mul r10, r8, r9
1BA10000 // add r11, r10, r1 (interlock)
7C990000 // mul r12, r9, r9
6D000001 // addi r13, r0, 1
2ECD0000 // sub r14, r12, r13 (product from EX2)
7F270000 // mul r15, r2, r7
51F90000 // xor r1, r15, r9 (interlock)
62000060 // addi r2, r0, 0x60
80200020 // bra r2 + 0x20
63000111 // squashed
64000222 // squashed
65000333 // squashed
@20
63300010 // addi r3, r3, 0x10
F0000000 // undefined opcode
64000444 // squashed
65000555 // squashed
66000666 // squashed
@40
64300001 // fault handler: addi r4, r3, 1
15440000 // add r5, r4, r4
80000180 // bra r0 + 0x180
66000777 // squashed
67000888 // squashed
68000999 // squashed
@60
76550000 // mul r6, r5, r5
17660000 // add r7, r6, r6 (interlock)
@80
00C01830 06006010 00180C00 80000600
@90
00000101 00000005
00000102 FFFFFFFD
00000103 00000002
00000104 FFFFFFFD
00000105 00000005
00000106 FFFFFFFD
00000107 FFFFFFF8
00000108 00001234
00000109 00005555
0000010A 06114F44
0000010B 06114F49
0000010C 1C718E39
0000010D 00000001
0000010E 1C718E38
0000010F 00000018
00000101 0000554D
00000102 00000060
00000200 00000080 // branch
00000103 00000012
00000300 00000100 // fault
00000104 00000013
00000105 00000026
00000200 00000180 // branch
00000106 000005A4
00000107 00000B48
00000000 00000000 // end

// File: list.f
common/corePkg.sv
source/fetchControl.sv
source/opDecode.sv
source/regFile.sv
source/hazardControl.sv
execute/aluUnit.sv
execute/mulUnit.sv
execute/exStage2.sv
source/execCore.sv
sim/execCoreTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = execCoreTb
FILELIST = list.f
BUILDDIR = obj_dir
BINARY   = $(BUILDDIR)/V$(TOP)
LOG      = sim.log
PASSTEXT = Simulation passed

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: sim/execCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module execCoreTb;

	localparam int patternWords = 256;
	localparam int romWords = 128; // 512 bytes, fetch wraps
	localparam int stallWords = 8;
	localparam int maxRecords = 56;
	localparam int romBase = 'h00;
	localparam int stallBase = 'h80;
	localparam int recordBase = 'h90;
	localparam int eventTimeout = 100; // cycles with no event at all
	localparam int drainCycles = 20;

	// record kinds in the pattern file
	localparam logic [7:0] kindEnd = 8'h00;
	localparam logic [7:0] kindWrite = 8'h01;
	localparam logic [7:0] kindBranch = 8'h02;
	localparam logic [7:0] kindFault = 8'h03;

	logic clock;
	logic reset;
	corePkg::word_t instrWord;
	logic fetchStall;
	corePkg::addr_t fetchPc;
	logic wbValid;
	corePkg::regId_t wbReg;
	corePkg::word_t wbData;
	logic faultTaken;

	logic [31:0] patternMem [patternWords];
	corePkg::word_t rom [romWords];
	logic [31:0] stallMap [stallWords];
	logic [7:0] recKind [maxRecords];
	corePkg::regId_t recReg [maxRecords];
	corePkg::word_t recValue [maxRecords];

	logic [31:0] lcgState;
	int stallCycle;
	int recIndex;
	corePkg::addr_t prevPc;

	execCore i_execCore
	(
		.clock(clock),
		.reset(reset),
		.instrWord(instrWord),
		.fetchStall(fetchStall),
		.fetchPc(fetchPc),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.faultTaken(faultTaken)
	);

	assign instrWord = rom[fetchPc[8:2]]; // combinational rom, word addressed

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// bit n of the map drives cycle n+1 after reset
	function automatic logic scheduledStall(input int cycle);
		logic [31:0] cycleWord;
		cycleWord = cycle;
		if (cycle >= stallWords * 32)
			return 1'b0;
		return stallMap[cycleWord[7:5]][cycleWord[4:0]];
	endfunction

	initial
	begin
		fetchStall = 1'b0;
		lcgState = 32'hb431;
		stallCycle = 0;
		forever
		begin
			@(posedge clock);
			if (!reset)
			begin
				lcgState = nextRandom(lcgState);
				// about one cycle in eight gets extra noise
				fetchStall <= scheduledStall(stallCycle) || lcgState[31:29] == 3'b000;
				stallCycle = stallCycle + 1;
			end
		end
	end

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "testbench stopped at the first failure");
	endtask

	task automatic checkWriteback(input corePkg::regId_t expReg, input corePkg::word_t expData);
		if (wbReg !== expReg || wbData !== expData)
			stopRun($sformatf("[ERROR] %0t ns: writeback r%0d = %h, expected r%0d = %h",
				$time, wbReg, wbData, expReg, expData));
	endtask

	task automatic checkPc(input corePkg::addr_t expPc);
		if (fetchPc !== expPc)
			stopRun($sformatf("[ERROR] %0t ns: fetchPc %h after redirect, expected %h",
				$time, fetchPc, expPc));
	endtask

	task automatic checkFault(input logic expTaken);
		if (faultTaken !== expTaken)
			stopRun($sformatf("[ERROR] %0t ns: faultTaken %b at redirect, expected %b",
				$time, faultTaken, expTaken));
	endtask

	task automatic loadPatterns();
		for (int i = 0; i < patternWords; i++)
			patternMem[i] = '0; // unused rom words decode as nop
		$readmemh("sim/corePatterns.txt", patternMem);
		for (int i = 0; i < romWords; i++)
			rom[i] = patternMem[romBase + i];
		for (int i = 0; i < stallWords; i++)
			stallMap[i] = patternMem[stallBase + i];
		for (int i = 0; i < maxRecords; i++)
		begin
			recKind[i] = patternMem[recordBase + 2 * i][15:8];
			recReg[i] = patternMem[recordBase + 2 * i][3:0];
			recValue[i] = patternMem[recordBase + 2 * i + 1];
		end
	endtask

	// a writeback retires only on an edge without stall
	task automatic followEvents();
		int idle;
		logic jumped;
		idle = 0;
		while (recKind[recIndex] != kindEnd)
		begin
			@(negedge clock);
			idle = idle + 1;
			jumped = fetchPc != prevPc && fetchPc != prevPc + corePkg::pcStep;
			if (wbValid && !fetchStall)
			begin
				if (recKind[recIndex] != kindWrite)
					stopRun($sformatf("[ERROR] %0t ns: writeback to r%0d where record %0d is none",
						$time, wbReg, recIndex));
				checkWriteback(recReg[recIndex], recValue[recIndex]);
				recIndex = recIndex + 1;
				idle = 0;
			end
			if (jumped)
			begin
				if (recKind[recIndex] != kindBranch && recKind[recIndex] != kindFault)
					stopRun($sformatf("[ERROR] %0t ns: redirect to %h where record %0d is none",
						$time, fetchPc, recIndex));
				checkFault(recKind[recIndex] == kindFault);
				checkPc(recValue[recIndex]);
				recIndex = recIndex + 1;
				idle = 0;
			end
			else if (faultTaken)
				stopRun("faultTaken pulsed but fetch did not move to a new address");
			prevPc = fetchPc;
			if (idle >= eventTimeout)
				stopRun($sformatf("no writeback or redirect for %0d cycles while waiting for record %0d",
					eventTimeout, recIndex));
		end
	endtask

	task automatic drainPipeline();
		repeat (drainCycles)
		begin
			@(negedge clock);
			if (wbValid && !fetchStall)
				stopRun($sformatf("[ERROR] %0t ns: extra writeback to r%0d after the last record",
					$time, wbReg));
			if (faultTaken || (fetchPc != prevPc && fetchPc != prevPc + corePkg::pcStep))
				stopRun($sformatf("[ERROR] %0t ns: extra redirect to %h after the last record",
					$time, fetchPc));
			prevPc = fetchPc;
		end
	endtask

	initial
	begin
		reset = 1'b1;
		loadPatterns();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		prevPc = corePkg::resetPc;
		recIndex = 0;
		followEvents();
		drainPipeline(); // nothing may follow the last record
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/execCore.sv
`timescale 1ns/1ns
`default_nettype none

module execCore
(
	input wire clock,
	input wire reset,
	input wire corePkg::word_t instrWord,
	input wire fetchStall,
	output corePkg::addr_t fetchPc,
	output logic wbValid,
	output corePkg::regId_t wbReg,
	output corePkg::word_t wbData,
	output logic faultTaken
);

	logic holdFront;
	logic holdAll;
	logic squash;

	// ID1
	corePkg::word_t id1Word;
	corePkg::opcode_t id1Opcode;
	corePkg::regId_t id1Rd;
	corePkg::regId_t id1Rs;
	corePkg::regId_t id1Rt;
	corePkg::word_t id1Imm;
	logic id1Undef;

	// ID2
	corePkg::opcode_t id2Opcode;
	corePkg::regId_t id2Rd;
	corePkg::regId_t id2Rs;
	corePkg::regId_t id2Rt;
	corePkg::word_t id2Imm;
	logic id2Undef;
	corePkg::word_t id2DataA;
	corePkg::word_t id2DataB;

	// EX1
	corePkg::opcode_t ex1Opcode;
	corePkg::regId_t ex1Rd;
	logic ex1Valid;
	logic ex1Undef;
	corePkg::word_t ex1SrcA;
	corePkg::word_t ex1SrcB;
	corePkg::word_t ex1Imm;
	logic ex1Live;
	logic ex1FwdValid;
	corePkg::opcode_t hazOpcode;
	corePkg::word_t aluResult;
	logic branchTaken;
	corePkg::addr_t branchTarget;
	logic braRequest;
	logic faultRequest;
	corePkg::word_t mulResult;

	assign ex1Live = ex1Valid && !squash;
	assign ex1FwdValid = ex1Live && ex1Opcode != corePkg::opMul && ex1Opcode != corePkg::opBra;
	assign hazOpcode = ex1Live ? ex1Opcode : corePkg::opNop; // dead mul never interlocks
	assign braRequest = branchTaken && ex1Live;
	assign faultRequest = ex1Undef && ex1Live;

	fetchControl i_fetchControl
	(
		.clock(clock),
		.reset(reset),
		.holdFront(holdFront),
		.holdAll(holdAll),
		.branchTaken(braRequest),
		.branchTarget(branchTarget),
		.faultRequest(faultRequest),
		.fetchPc(fetchPc),
		.squash(squash),
		.faultTaken(faultTaken)
	);

	hazardControl i_hazardControl
	(
		.fetchStall(fetchStall),
		.ex1Opcode(hazOpcode),
		.ex1Dest(ex1Rd),
		.id2SrcA(id2Rs),
		.id2SrcB(id2Rt),
		.holdFront(holdFront),
		.holdAll(holdAll)
	);

	opDecode i_opDecode
	(
		.instrWord(id1Word),
		.opcode(id1Opcode),
		.rd(id1Rd),
		.rs(id1Rs),
		.rt(id1Rt),
		.imm(id1Imm),
		.undefinedOp(id1Undef)
	);

	regFile i_regFile
	(
		.clock(clock),
		.reset(reset),
		.readIdA(id2Rs),
		.readIdB(id2Rt),
		.readDataA(id2DataA),
		.readDataB(id2DataB),
		.ex1Id(ex1Rd),
		.ex1Data(aluResult),
		.ex1Valid(ex1FwdValid),
		.ex2Id(wbReg),
		.ex2Data(wbData),
		.ex2Valid(wbValid),
		.holdAll(holdAll)
	);

	aluUnit i_aluUnit
	(
		.opcode(ex1Opcode),
		.srcA(ex1SrcA),
		.srcB(ex1SrcB),
		.imm(ex1Imm),
		.aluResult(aluResult),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	mulUnit i_mulUnit
	(
		.clock(clock),
		.reset(reset),
		.holdAll(holdAll),
		.srcA(ex1SrcA),
		.srcB(ex1SrcB),
		.mulResult(mulResult)
	);

	exStage2 i_exStage2
	(
		.clock(clock),
		.reset(reset),
		.holdAll(holdAll),
		.ex1Opcode(ex1Opcode),
		.ex1Dest(ex1Rd),
		.ex1Valid(ex1Live),
		.aluResult(aluResult),
		.mulResult(mulResult),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	// front stages, frozen by stall and interlock
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			id1Word <= '0; // all-zero word decodes as nop
			id2Opcode <= corePkg::opNop;
			id2Rd <= corePkg::zeroReg;
			id2Undef <= 1'b0;
		end
		else if (!holdFront)
		begin
			id1Word <= instrWord;
			id2Opcode <= id1Opcode;
			id2Rd <= id1Rd;
			id2Undef <= id1Undef;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!holdFront)
		begin
			id2Rs <= id1Rs;
			id2Rt <= id1Rt;
			id2Imm <= id1Imm;
			ex1SrcA <= id2DataA;
			ex1SrcB <= id2DataB;
			ex1Imm <= id2Imm;
		end
	end

	// EX1 slot control
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex1Opcode <= corePkg::opNop;
			ex1Rd <= corePkg::zeroReg;
			ex1Valid <= 1'b0;
			ex1Undef <= 1'b0;
		end
		else if (!holdAll)
		begin
			if (holdFront)
			begin
				// interlock bubble while the product finishes
				ex1Opcode <= corePkg::opNop;
				ex1Rd <= corePkg::zeroReg;
				ex1Valid <= 1'b0;
				ex1Undef <= 1'b0;
			end
			else
			begin
				ex1Opcode <= id2Opcode;
				ex1Rd <= id2Rd;
				ex1Valid <= 1'b1;
				ex1Undef <= id2Undef;
			end
		end
	end

endmodule

`default_nettype wire

// File: execute/exStage2.sv
`timescale 1ns/1ns
`default_nettype none

module exStage2
(
	input wire clock,
	input wire reset,
	input wire holdAll,
	input wire corePkg::opcode_t ex1Opcode,
	input wire corePkg::regId_t ex1Dest,
	input wire ex1Valid,
	input wire corePkg::word_t aluResult,
	input wire corePkg::word_t mulResult,
	output logic wbValid,
	output corePkg::regId_t wbReg,
	output corePkg::word_t wbData
);

	corePkg::opcode_t ex2Opcode;
	corePkg::regId_t ex2Dest;
	logic ex2Valid;
	corePkg::word_t ex2Alu;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex2Opcode <= corePkg::opNop;
			ex2Dest <= corePkg::zeroReg;
			ex2Valid <= 1'b0;
		end
		else if (!holdAll)
		begin
			ex2Opcode <= ex1Opcode;
			ex2Dest <= ex1Dest;
			ex2Valid <= ex1Valid; // bubbles and squashed slots arrive invalid
		end
	end

	always_ff @(posedge clock)
	begin
		if (!holdAll)
			ex2Alu <= aluResult;
	end

	assign wbValid = ex2Valid && (ex2Opcode != corePkg::opBra) &&
		(ex2Dest != corePkg::zeroReg);
	assign wbReg = ex2Dest;
	assign wbData = (ex2Opcode == corePkg::opMul) ? mulResult : ex2Alu; // product finishes here

	// held slot keeps presenting the same writeback and product
	assert property (@(posedge clock) disable iff (reset)
		holdAll |=> $stable(wbValid) && $stable(wbReg) && $stable(wbData))
		else $error("writeback changed while the pipeline was held");

endmodule

`default_nettype wire

// File: execute/mulUnit.sv
`timescale 1ns/1ns
`default_nettype none

module mulUnit
(
	input wire clock,
	input wire reset,
	input wire holdAll,
	input wire corePkg::word_t srcA,
	input wire corePkg::word_t srcB,
	output corePkg::word_t mulResult
);

	localparam int halfWidth = corePkg::dataWidth / 2;

	corePkg::word_t prodLoLo;
	corePkg::word_t prodLoHi;
	corePkg::word_t prodHiLo;
	corePkg::word_t crossSum;

	// hi * hi lands above bit 31 and is dropped
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			prodLoLo <= '0;
			prodLoHi <= '0;
			prodHiLo <= '0;
		end
		else if (!holdAll)
		begin
			prodLoLo <= srcA[halfWidth-1:0] * srcB[halfWidth-1:0];
			prodLoHi <= srcA[halfWidth-1:0] * srcB[corePkg::dataWidth-1:halfWidth];
			prodHiLo <= srcA[corePkg::dataWidth-1:halfWidth] * srcB[halfWidth-1:0];
		end
	end

	// second half runs in EX2
	assign crossSum = prodLoHi + prodHiLo;
	assign mulResult = prodLoLo + (crossSum << halfWidth);

endmodule

`default_nettype wire

// File: execute/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit
(
	input wire corePkg::opcode_t opcode,
	input wire corePkg::word_t srcA,
	input wire corePkg::word_t srcB,
	input wire corePkg::word_t imm,
	output corePkg::word_t aluResult,
	output logic branchTaken,
	output corePkg::addr_t branchTarget
);

	corePkg::word_t immSum;

	assign immSum = srcA + imm; // shared by addi and bra

	always_comb
	begin
		case (opcode)
			corePkg::opAdd: aluResult = srcA + srcB;
			corePkg::opSub: aluResult = srcA - srcB;
			corePkg::opAnd: aluResult = srcA & srcB;
			corePkg::opOr: aluResult = srcA | srcB;
			corePkg::opXor: aluResult = srcA ^ srcB;
			corePkg::opAddi: aluResult = immSum;
			default: aluResult = '0; // nop, bra, mul
		endcase
	end

	// unconditional, slot validity is checked by the core
	assign branchTaken = (opcode == corePkg::opBra);
	assign branchTarget = immSum;

endmodule

`default_nettype wire

// File: source/hazardControl.sv
`timescale 1ns/1ns
`default_nettype none

module hazardControl
(
	input wire fetchStall,
	input wire corePkg::opcode_t ex1Opcode,
	input wire corePkg::regId_t ex1Dest,
	input wire corePkg::regId_t id2SrcA,
	input wire corePkg::regId_t id2SrcB,
	output logic holdFront,
	output logic holdAll
);

	logic mulPending;
	logic mulConflict;

	// product only exists one stage later, so it cannot be forwarded from EX1
	assign mulPending = (ex1Opcode == corePkg::opMul) && (ex1Dest != corePkg::zeroReg);
	assign mulConflict = mulPending && (ex1Dest == id2SrcA || ex1Dest == id2SrcB);

	assign holdAll = fetchStall; // instruction not there yet
	assign holdFront = holdAll || mulConflict;

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
(
	input wire clock,
	input wire reset,
	input wire corePkg::regId_t readIdA,
	input wire corePkg::regId_t readIdB,
	output corePkg::word_t readDataA,
	output corePkg::word_t readDataB,
	input wire corePkg::regId_t ex1Id,
	input wire corePkg::word_t ex1Data,
	input wire ex1Valid,
	input wire corePkg::regId_t ex2Id,
	input wire corePkg::word_t ex2Data,
	input wire ex2Valid,
	input wire holdAll
);

	corePkg::word_t registers [2**corePkg::regIdWidth];

	// youngest producer wins
	function automatic corePkg::word_t forward(input corePkg::regId_t id);
		if (id == corePkg::zeroReg)
			return '0;
		if (ex1Valid && ex1Id == id)
			return ex1Data;
		if (ex2Valid && ex2Id == id)
			return ex2Data;
		return registers[id];
	endfunction

	always_comb
	begin
		readDataA = forward(readIdA);
		readDataB = forward(readIdB);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**corePkg::regIdWidth; i++)
				registers[i] <= '0;
		end
		else if (!holdAll && ex2Valid && ex2Id != corePkg::zeroReg)
			registers[ex2Id] <= ex2Data; // EX2 retires here
	end

	assert property (@(posedge clock) disable iff (reset)
		(readIdA != corePkg::zeroReg || readDataA == '0) &&
		(readIdB != corePkg::zeroReg || readDataB == '0))
		else $error("register 0 read back non-zero");

endmodule

`default_nettype wire

// File: source/opDecode.sv
`timescale 1ns/1ns
`default_nettype none

module opDecode
(
	input wire corePkg::word_t instrWord,
	output corePkg::opcode_t opcode,
	output corePkg::regId_t rd,
	output corePkg::regId_t rs,
	output corePkg::regId_t rt,
	output corePkg::word_t imm,
	output logic undefinedOp
);

	logic [corePkg::opcodeWidth-1:0] rawOp;
	logic immSign;

	assign rawOp = instrWord[corePkg::opcodeField +: corePkg::opcodeWidth];
	assign rs = instrWord[corePkg::rsField +: corePkg::regIdWidth];
	assign rt = instrWord[corePkg::rtField +: corePkg::regIdWidth];

	// sign extend the 16-bit field
	assign immSign = instrWord[corePkg::immField + corePkg::immWidth - 1];
	assign imm = {{(corePkg::dataWidth - corePkg::immWidth){immSign}},
		instrWord[corePkg::immField +: corePkg::immWidth]};

	always_comb
	begin
		opcode = corePkg::opcode_t'(rawOp);
		rd = instrWord[corePkg::rdField +: corePkg::regIdWidth];
		undefinedOp = 1'b0;
		case (corePkg::opcode_t'(rawOp))
			corePkg::opNop: rd = corePkg::zeroReg; // nop never writes
			corePkg::opAdd, corePkg::opSub, corePkg::opAnd, corePkg::opOr,
			corePkg::opXor, corePkg::opAddi, corePkg::opMul, corePkg::opBra:
				undefinedOp = 1'b0;
			default:
			begin
				// travels down as a nop, EX1 raises the fault
				undefinedOp = 1'b1;
				opcode = corePkg::opNop;
				rd = corePkg::zeroReg;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/fetchControl.sv
`timescale 1ns/1ns
`default_nettype none

module fetchControl
(
	input wire clock,
	input wire reset,
	input wire holdFront,
	input wire holdAll,
	input wire branchTaken,
	input wire corePkg::addr_t branchTarget,
	input wire faultRequest,
	output corePkg::addr_t fetchPc,
	output logic squash,
	output logic faultTaken
);

	logic [corePkg::flushDepth-1:0] flushMask; // bit 0 is the slot now in EX1
	corePkg::addr_t nextPc;
	logic redirect;

	// nothing moves while the whole pipe is held
	assign redirect = (branchTaken || faultRequest) && !holdAll;
	assign squash = flushMask[0];

	always_comb
	begin
		if (faultRequest && !holdAll)
			nextPc = corePkg::faultVector;
		else if (branchTaken && !holdAll)
			nextPc = branchTarget;
		else if (holdFront)
			nextPc = fetchPc; // interlock or stall
		else
			nextPc = fetchPc + corePkg::pcStep;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetchPc <= corePkg::resetPc;
			flushMask <= '1; // first slots after reset are empty
			faultTaken <= 1'b0;
		end
		else
		begin
			fetchPc <= nextPc;
			faultTaken <= faultRequest && !holdAll;
			if (!holdAll)
				flushMask <= redirect ? '1 : (flushMask >> 1);
		end
	end

	assert property (@(posedge clock) disable iff (reset) fetchPc[1:0] == 2'b00)
		else $error("fetchPc not word aligned: %h", fetchPc);

	// a squashed EX1 slot must never steer fetch
	assert property (@(posedge clock) disable iff (reset) redirect |-> !squash)
		else $error("redirect taken from a squashed slot");

endmodule

`default_nettype wire

// File: common/corePkg.sv
`default_nettype none

package corePkg;

	// machine widths
	localparam int dataWidth = 32;
	localparam int regIdWidth = 4; // 16 registers
	localparam int opcodeWidth = 4;
	localparam int immWidth = 16;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [dataWidth-1:0] addr_t;
	typedef logic [regIdWidth-1:0] regId_t;

	// codes above opBra are undefined and raise a fault
	typedef enum logic [opcodeWidth-1:0]
	{
		opNop  = 4'h0,
		opAdd  = 4'h1,
		opSub  = 4'h2,
		opAnd  = 4'h3,
		opOr   = 4'h4,
		opXor  = 4'h5,
		opAddi = 4'h6, // rs + sign-extended imm
		opMul  = 4'h7, // low word of rs * rt
		opBra  = 4'h8  // pc = rs + imm
	} opcode_t;

	localparam regId_t zeroReg = '0; // reads as zero, writes dropped

	// fetch sequencing
	localparam addr_t pcStep = 32'd4;
	localparam addr_t resetPc = 32'h0000_0000;
	localparam addr_t faultVector = 32'h0000_0100;
	localparam int flushDepth = 3; // IF, ID1, ID2 behind a redirect

	// low bit of each instruction field
	localparam int opcodeField = 28; // 31:28
	localparam int rdField = 24;     // 27:24
	localparam int rsField = 20;     // 23:20
	localparam int rtField = 16;     // 19:16
	localparam int immField = 0;     // 15:0

endpackage

`default_nettype wire
